//--- source/periph_settings.svh
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// register bus
`define PERIPH_DATA_W 32
`define PERIPH_ADDR_W 16
`define PERIPH_OFS_W 6

// unit regions, address bits 15:12
`define PERIPH_REGION_IRQ 4'd0
`define PERIPH_REGION_UART 4'd1
`define PERIPH_REGION_TIMER 4'd2

// interrupt controller
`define PERIPH_NUM_SRC 3
`define PERIPH_NUM_TGT 2
`define PERIPH_PRIO_W 3

// timers and uart
`define PERIPH_NUM_TIMERS 2
`define PERIPH_UART_DIV_RESET 32'd4

// read data of the error answer
`define PERIPH_BAD_DATA 32'hDEADBEEF

`endif

//--- source/periph_pkg.sv
`include "periph_settings.svh"

package periph_pkg;

    // ------------------------------------------------------------
    // register bus as seen from the master
    // ------------------------------------------------------------

    // single-cycle strobe, no handshake
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } reg_req_t;

    // pulsed one cycle after the request
    typedef struct packed {
        logic                      valid;
        logic                      error;
        logic [`PERIPH_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // ------------------------------------------------------------
    // strobe toward one unit
    // ------------------------------------------------------------

    // rd and wr are only set in a cycle that hits the unit
    typedef struct packed {
        logic                      rd;
        logic                      wr;
        logic [`PERIPH_OFS_W-1:0]  ofs;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } unit_req_t;

endpackage

//--- source/periph_bus_ctrl.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_bus_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  periph_pkg::reg_req_t      req_i,
    output periph_pkg::unit_req_t     irq_req_o,
    output periph_pkg::unit_req_t     uart_req_o,
    output periph_pkg::unit_req_t     timer_req_o,
    input  logic [`PERIPH_DATA_W-1:0] irq_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0] uart_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0] timer_rdata_i,
    output periph_pkg::reg_rsp_t      rsp_o
);

    logic [3:0]                region;
    logic                      hit_irq;
    logic                      hit_uart;
    logic                      hit_timer;
    logic                      mapped;
    logic [`PERIPH_DATA_W-1:0] rdata_sel;

    logic                      rsp_valid_q;
    logic                      rsp_error_q;
    logic [`PERIPH_DATA_W-1:0] rsp_rdata_q;

    function automatic periph_pkg::unit_req_t unit_req(input periph_pkg::reg_req_t req,
                                                       input logic hit);
        periph_pkg::unit_req_t r;
        r.rd    = req.valid & ~req.write & hit;
        r.wr    = req.valid & req.write & hit;
        r.ofs   = req.addr[`PERIPH_OFS_W-1:0];
        r.wdata = req.wdata;
        return r;
    endfunction

    // ------------------------------------------------------------
    // region decode
    // ------------------------------------------------------------
    assign region    = req_i.addr[`PERIPH_ADDR_W-1 -: 4];
    assign hit_irq   = (region == `PERIPH_REGION_IRQ);
    assign hit_uart  = (region == `PERIPH_REGION_UART);
    assign hit_timer = (region == `PERIPH_REGION_TIMER);
    assign mapped    = hit_irq | hit_uart | hit_timer;

    assign irq_req_o   = unit_req(req_i, hit_irq);
    assign uart_req_o  = unit_req(req_i, hit_uart);
    assign timer_req_o = unit_req(req_i, hit_timer);

    // writes answer zero unless unmapped
    always_comb begin
        if (!mapped) begin
            rdata_sel = `PERIPH_BAD_DATA;
        end else if (req_i.write) begin
            rdata_sel = '0;
        end else if (hit_irq) begin
            rdata_sel = irq_rdata_i;
        end else if (hit_uart) begin
            rdata_sel = uart_rdata_i;
        end else begin
            rdata_sel = timer_rdata_i;
        end
    end

    // ------------------------------------------------------------
    // response, one cycle after the request
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            rsp_error_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
            rsp_error_q <= req_i.valid & ~mapped;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rsp_rdata_q <= rdata_sel;
        end
    end

    assign rsp_o = '{valid: rsp_valid_q, error: rsp_error_q, rdata: rsp_rdata_q};

endmodule

//--- source/periph_irq_ctrl.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_irq_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  periph_pkg::unit_req_t     req_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    input  logic [`PERIPH_NUM_SRC-1:0] src_i,
    output logic [`PERIPH_NUM_TGT-1:0] irq_o
);

    localparam int NS   = `PERIPH_NUM_SRC;
    localparam int NT   = `PERIPH_NUM_TGT;
    localparam int PW   = `PERIPH_PRIO_W;
    localparam int ID_W = $clog2(NS + 1);

    // word index of each register group
    localparam int EN_WORD  = 4;
    localparam int THR_WORD = 6;
    localparam int CLM_WORD = 8;

    logic [3:0]                word;
    logic [ID_W-1:0]           cid;

    logic [NS:1][PW-1:0]       prio_q;
    logic [NT-1:0][NS:1]       en_q;
    logic [NT-1:0][PW-1:0]     thr_q;
    logic [NS:1]               claimed_q;

    logic [NS:1]               pending;
    logic [NT-1:0][ID_W-1:0]   best_id;

    assign word    = req_i.ofs[`PERIPH_OFS_W-1:2];
    assign cid     = req_i.wdata[ID_W-1:0];
    assign pending = src_i & ~claimed_q;

    // ------------------------------------------------------------
    // arbitration per target
    // ------------------------------------------------------------
    always_comb begin : arbiter
        logic [PW-1:0] lvl;
        best_id = '0;
        lvl     = '0;
        for (int t = 0; t < NT; t++) begin
            lvl = thr_q[t];
            // strict compare keeps the lower id on a tie
            for (int s = 1; s <= NS; s++) begin
                if (pending[s] && en_q[t][s] && prio_q[s] > lvl) begin
                    best_id[t] = ID_W'(s);
                    lvl        = prio_q[s];
                end
            end
            irq_o[t] = (best_id[t] != '0);
        end
    end

    // ------------------------------------------------------------
    // register writes, claim and complete
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_q    <= '0;
            en_q      <= '0;
            thr_q     <= '0;
            claimed_q <= '0;
        end else begin
            if (req_i.wr) begin
                for (int s = 1; s <= NS; s++) begin
                    if (word == s) begin
                        prio_q[s] <= req_i.wdata[PW-1:0];
                    end
                end
                for (int t = 0; t < NT; t++) begin
                    if (word == EN_WORD + t) begin
                        en_q[t] <= req_i.wdata[NS:1];
                    end
                    if (word == THR_WORD + t) begin
                        thr_q[t] <= req_i.wdata[PW-1:0];
                    end
                    if (word == CLM_WORD + t && cid != '0 && cid <= NS) begin
                        claimed_q[cid] <= 1'b0;
                    end
                end
            end
            // claim read puts the winner in service
            if (req_i.rd) begin
                for (int t = 0; t < NT; t++) begin
                    if (word == CLM_WORD + t && best_id[t] != '0) begin
                        claimed_q[best_id[t]] <= 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.rd) begin
            for (int s = 1; s <= NS; s++) begin
                if (word == s) begin
                    rdata_o[PW-1:0] = prio_q[s];
                end
            end
            for (int t = 0; t < NT; t++) begin
                if (word == EN_WORD + t) begin
                    rdata_o[NS:1] = en_q[t];
                end
                if (word == THR_WORD + t) begin
                    rdata_o[PW-1:0] = thr_q[t];
                end
                if (word == CLM_WORD + t) begin
                    rdata_o[ID_W-1:0] = best_id[t];
                end
            end
        end
    end

endmodule

//--- source/periph_timer.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_timer (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  periph_pkg::unit_req_t        req_i,
    output logic [`PERIPH_DATA_W-1:0]    rdata_o,
    output logic [`PERIPH_NUM_TIMERS-1:0] irq_o
);

    localparam int NT = `PERIPH_NUM_TIMERS;
    localparam int DW = `PERIPH_DATA_W;

    logic [1:0]            tsel;
    logic [1:0]            rsel;

    logic [NT-1:0]         en_q;
    logic [NT-1:0]         pend_q;
    logic [NT-1:0][DW-1:0] cnt_q;
    logic [NT-1:0][DW-1:0] cmp_q;

    // 16 bytes per timer
    assign tsel = req_i.ofs[`PERIPH_OFS_W-1 -: 2];
    assign rsel = req_i.ofs[3:2];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q   <= '0;
            pend_q <= '0;
            cnt_q  <= '0;
        end else begin
            for (int i = 0; i < NT; i++) begin
                if (en_q[i]) begin
                    if (cnt_q[i] == cmp_q[i]) begin
                        cnt_q[i] <= '0;
                    end else begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end
                if (req_i.wr && tsel == i) begin
                    if (rsel == 2'd0) begin
                        en_q[i] <= req_i.wdata[0];
                    end
                    if (rsel == 2'd3) begin
                        pend_q[i] <= 1'b0;
                    end
                end
                // a new match wins over a clear
                if (en_q[i] && cnt_q[i] == cmp_q[i]) begin
                    pend_q[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NT; i++) begin
            if (req_i.wr && tsel == i && rsel == 2'd1) begin
                cmp_q[i] <= req_i.wdata;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NT; i++) begin
            if (req_i.rd && tsel == i) begin
                case (rsel)
                    2'd0:    rdata_o = {{(DW-1){1'b0}}, en_q[i]};
                    2'd1:    rdata_o = cmp_q[i];
                    2'd2:    rdata_o = cnt_q[i];
                    default: rdata_o = {{(DW-1){1'b0}}, pend_q[i]};
                endcase
            end
        end
    end

    assign irq_o = pend_q;

endmodule

//--- source/periph_uart_tx.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_uart_tx (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  periph_pkg::unit_req_t     req_i,
    output logic [`PERIPH_DATA_W-1:0] rdata_o,
    output logic                      tx_o,
    output logic                      irq_o
);

    localparam int DW = `PERIPH_DATA_W;

    logic [3:0]    word;
    logic          load;
    logic          bit_end;

    logic          busy_q;
    logic          ie_q;
    logic [DW-1:0] div_q;
    logic [DW-1:0] baud_cnt_q;
    logic [3:0]    bit_cnt_q;
    logic [9:0]    shift_q;

    assign word    = req_i.ofs[`PERIPH_OFS_W-1:2];
    assign load    = req_i.wr && word == 4'd0 && !busy_q;
    // divisor of 0 or 1 gives one cycle per bit
    assign bit_end = (baud_cnt_q + 1'b1) >= div_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            ie_q       <= 1'b0;
            div_q      <= `PERIPH_UART_DIV_RESET;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else begin
            if (req_i.wr && word == 4'd1) begin
                div_q <= req_i.wdata;
            end
            if (req_i.wr && word == 4'd3) begin
                ie_q <= req_i.wdata[0];
            end
            if (load) begin
                busy_q     <= 1'b1;
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end else if (busy_q) begin
                if (bit_end) begin
                    baud_cnt_q <= '0;
                    bit_cnt_q  <= bit_cnt_q + 1'b1;
                    // stop bit done
                    if (bit_cnt_q == 4'd9) begin
                        busy_q <= 1'b0;
                    end
                end else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
            end
        end
    end

    // 8N1 frame, lsb first
    always_ff @(posedge clk_i) begin
        if (load) begin
            shift_q <= {1'b1, req_i.wdata[7:0], 1'b0};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[9:1]};
        end
    end

    always_comb begin
        rdata_o = '0;
        if (req_i.rd) begin
            case (word)
                4'd1:    rdata_o = div_q;
                4'd2:    rdata_o[0] = busy_q;
                4'd3:    rdata_o[0] = ie_q;
                default: rdata_o = '0;
            endcase
        end
    end

    assign tx_o  = busy_q ? shift_q[0] : 1'b1;
    assign irq_o = ie_q & ~busy_q;

endmodule

//--- source/periph_top.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  periph_pkg::reg_req_t       req_i,
    output periph_pkg::reg_rsp_t       rsp_o,
    output logic [`PERIPH_NUM_TGT-1:0] irq_o,
    output logic                       tx_o
);

    periph_pkg::unit_req_t          irq_req;
    periph_pkg::unit_req_t          uart_req;
    periph_pkg::unit_req_t          timer_req;
    logic [`PERIPH_DATA_W-1:0]      irq_rdata;
    logic [`PERIPH_DATA_W-1:0]      uart_rdata;
    logic [`PERIPH_DATA_W-1:0]      timer_rdata;
    logic                           uart_irq;
    logic [`PERIPH_NUM_TIMERS-1:0]  timer_irq;

    periph_bus_ctrl i_bus_ctrl (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .req_i         ( req_i       ),
        .irq_req_o     ( irq_req     ),
        .uart_req_o    ( uart_req    ),
        .timer_req_o   ( timer_req   ),
        .irq_rdata_i   ( irq_rdata   ),
        .uart_rdata_i  ( uart_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .rsp_o         ( rsp_o       )
    );

    // ------------------------------------------------------------
    // sources: 1 uart, 2 timer 0, 3 timer 1
    // ------------------------------------------------------------
    periph_irq_ctrl i_irq_ctrl (
        .clk_i   ( clk_i                 ),
        .rst_i   ( rst_i                 ),
        .req_i   ( irq_req               ),
        .rdata_o ( irq_rdata             ),
        .src_i   ( {timer_irq, uart_irq} ),
        .irq_o   ( irq_o                 )
    );

    periph_uart_tx i_uart_tx (
        .clk_i   ( clk_i      ),
        .rst_i   ( rst_i      ),
        .req_i   ( uart_req   ),
        .rdata_o ( uart_rdata ),
        .tx_o    ( tx_o       ),
        .irq_o   ( uart_irq   )
    );

    periph_timer i_timer (
        .clk_i   ( clk_i       ),
        .rst_i   ( rst_i       ),
        .req_i   ( timer_req   ),
        .rdata_o ( timer_rdata ),
        .irq_o   ( timer_irq   )
    );

endmodule

//--- verification/periph_tb.sv
`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_tb;

    localparam int UART_DIV = 4;

    logic                       clk = 1'b0;
    logic                       rst;
    periph_pkg::reg_req_t       req;
    periph_pkg::reg_rsp_t       rsp;
    logic [`PERIPH_NUM_TGT-1:0] irq;
    logic                       tx;

    // pattern table
    bit          pat_wr[$];
    logic [15:0] pat_addr[$];
    logic [31:0] pat_wdata[$];
    logic [31:0] pat_rdata[$];
    bit          pat_err[$];

    bit          load_done = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_errors = 0;

    periph_top uut (
        .clk_i ( clk ),
        .rst_i ( rst ),
        .req_i ( req ),
        .rsp_o ( rsp ),
        .irq_o ( irq ),
        .tx_o  ( tx  )
    );

    always #50 clk = ~clk;

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
    endtask

    // ------------------------------------------------------------
    // bus access, response expected exactly one cycle later
    // ------------------------------------------------------------
    task automatic bus_access(input bit wr, input logic [15:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output bit err);
        @(posedge clk);
        req.valid <= 1'b1;
        req.write <= wr;
        req.addr  <= addr;
        req.wdata <= wdata;
        @(negedge clk);
        expect_equal($sformatf("no early response for %h", addr), rsp.valid, 1'b0);
        @(posedge clk);
        req.valid <= 1'b0;
        @(negedge clk);
        expect_equal($sformatf("response valid for %h", addr), rsp.valid, 1'b1);
        rdata = rsp.rdata;
        err   = rsp.error;
    endtask

    task automatic reg_write(input logic [15:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        bit          err;
        bus_access(1'b1, addr, wdata, rdata, err);
        expect_equal($sformatf("write %h error flag", addr), err, 1'b0);
    endtask

    task automatic reg_read(input logic [15:0] addr, output logic [31:0] rdata);
        bit err;
        bus_access(1'b0, addr, '0, rdata, err);
        expect_equal($sformatf("read %h error flag", addr), err, 1'b0);
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] rdata;
        reg_read(addr, rdata);
        expect_equal(what, rdata, exp);
    endtask

    task automatic wait_irq(input int tgt, input logic level, input int max_cycles,
                            output bit seen);
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(negedge clk);
            seen = (irq[tgt] === level);
        end
    endtask

    // lines starting with # are skipped
    task automatic load_patterns(output bit ok);
        int          fd;
        int          n;
        int          err;
        string       op;
        string       rest;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        ok = 1'b0;
        fd = $fopen("verification/periph_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/periph_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                break;
            end
            if (op == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %d", addr, wdata, rdata, err);
                if (n != 4) begin
                    $display("malformed line in the pattern file after op %s", op);
                    $fclose(fd);
                    return;
                end
                pat_wr.push_back(op == "W");
                pat_addr.push_back(addr);
                pat_wdata.push_back(wdata);
                pat_rdata.push_back(rdata);
                pat_err.push_back(err[0]);
            end
        end
        $fclose(fd);
        ok = (pat_wr.size() > 0);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic check_reset_state();
        begin_test();
        @(negedge clk);
        expect_equal("rsp valid after reset", rsp.valid, 1'b0);
        expect_equal("irq after reset", irq, 2'b00);
        expect_equal("tx idle after reset", tx, 1'b1);
        end_test("reset state");
    endtask

    task automatic run_patterns();
        logic [31:0] rdata;
        bit          err;
        begin_test();
        for (int i = 0; i < pat_wr.size(); i++) begin
            bus_access(pat_wr[i], pat_addr[i], pat_wdata[i], rdata, err);
            expect_equal($sformatf("pattern %0d read data", i), rdata, pat_rdata[i]);
            expect_equal($sformatf("pattern %0d error flag", i), err, pat_err[i]);
        end
        end_test("register patterns");
    endtask

    task automatic probe_unmapped();
        logic [31:0] rdata;
        logic [15:0] addr;
        bit          err;
        begin_test();
        // known contents at offset 4 of every unit
        reg_write(16'h0004, 32'd5);
        reg_write(16'h1004, UART_DIV);
        reg_write(16'h2004, 32'h5A5A0F0F);
        for (int r = 3; r < 16; r++) begin
            addr = {r[3:0], 12'h004};
            bus_access(1'b1, addr, $urandom, rdata, err);
            expect_equal($sformatf("write %h error flag", addr), err, 1'b1);
            expect_equal($sformatf("write %h error data", addr), rdata, `PERIPH_BAD_DATA);
            bus_access(1'b0, addr, '0, rdata, err);
            expect_equal($sformatf("read %h error flag", addr), err, 1'b1);
            expect_equal($sformatf("read %h error data", addr), rdata, `PERIPH_BAD_DATA);
        end
        read_expect(16'h0004, 32'd5, "priority after unmapped writes");
        read_expect(16'h1004, UART_DIV, "divisor after unmapped writes");
        read_expect(16'h2004, 32'h5A5A0F0F, "compare after unmapped writes");
        end_test("unmapped regions");
    endtask

    task automatic timer_claim();
        logic [31:0] cmp;
        bit          seen;
        begin_test();
        cmp = $urandom % 64;
        reg_write(16'h0008, 32'd3);
        // target 0 takes source 2 only
        reg_write(16'h0010, 32'h4);
        reg_write(16'h0018, 32'd0);
        reg_write(16'h2004, cmp);
        reg_write(16'h2000, 32'd1);
        wait_irq(0, 1'b1, int'(cmp) + 4, seen);
        expect_equal($sformatf("timer irq within %0d cycles", cmp + 4), seen, 1'b1);
        read_expect(16'h0020, 32'd2, "claim target 0 after timer match");
        expect_equal("irq after claim", irq[0], 1'b0);
        reg_write(16'h2000, 32'd0);
        reg_write(16'h200C, 32'd0);
        reg_write(16'h0020, 32'd2);
        repeat (4) begin
            @(negedge clk);
            expect_equal("irq after clear and complete", irq[0], 1'b0);
        end
        end_test("timer and claim");
    endtask

    task automatic arbitration();
        logic [31:0] p0;
        logic [31:0] p1;
        bit          both;
        begin_test();
        reg_write(16'h0008, 32'd2);
        reg_write(16'h000C, 32'd5);
        reg_write(16'h0010, 32'hC);
        reg_write(16'h0018, 32'd0);
        // above any count left over from the last test
        reg_write(16'h2004, 32'd64 + ($urandom % 8));
        reg_write(16'h2014, 32'd64 + ($urandom % 8));
        reg_write(16'h2000, 32'd1);
        reg_write(16'h2010, 32'd1);
        both = 1'b0;
        for (int i = 0; i < 60 && !both; i++) begin
            reg_read(16'h200C, p0);
            reg_read(16'h201C, p1);
            both = p0[0] && p1[0];
        end
        expect_equal("both timers pending", both, 1'b1);
        reg_write(16'h2000, 32'd0);
        reg_write(16'h2010, 32'd0);
        expect_equal("irq with both sources pending", irq[0], 1'b1);
        read_expect(16'h0020, 32'd3, "claim picks priority 5");
        reg_write(16'h0020, 32'd3);
        reg_write(16'h0018, 32'd5);
        expect_equal("irq at threshold 5", irq[0], 1'b0);
        read_expect(16'h0020, 32'd0, "claim at threshold 5");
        reg_write(16'h0018, 32'd0);
        reg_write(16'h000C, 32'd2);
        read_expect(16'h0020, 32'd2, "equal priorities give lower id");
        reg_write(16'h0020, 32'd2);
        reg_write(16'h200C, 32'd0);
        reg_write(16'h201C, 32'd0);
        reg_write(16'h0010, 32'd0);
        end_test("arbitration and threshold");
    endtask

    task automatic uart_frame();
        logic [7:0]  data;
        logic [31:0] st;
        logic        exp_bit;
        bit          idle;
        begin_test();
        reg_write(16'h1004, UART_DIV);
        reg_write(16'h0004, 32'd6);
        reg_write(16'h0014, 32'h2);
        reg_write(16'h001C, 32'd0);
        reg_write(16'h100C, 32'd1);
        expect_equal("uart irq while idle", irq[1], 1'b1);
        for (int f = 0; f < 2; f++) begin
            data = 8'($urandom);
            reg_write(16'h1000, {24'd0, data});
            // move to the centre of the start bit
            repeat (UART_DIV / 2) @(negedge clk);
            for (int b = 0; b < 10; b++) begin
                if (b == 0) begin
                    exp_bit = 1'b0;
                    expect_equal("uart irq while busy", irq[1], 1'b0);
                end else if (b == 9) begin
                    exp_bit = 1'b1;
                end else begin
                    exp_bit = data[b-1];
                end
                expect_equal($sformatf("frame %0d (%h) bit %0d", f, data, b), tx, exp_bit);
                repeat (UART_DIV) @(negedge clk);
            end
            idle = 1'b0;
            for (int i = 0; i < 20 && !idle; i++) begin
                reg_read(16'h1008, st);
                idle = !st[0];
            end
            expect_equal($sformatf("uart idle after frame %0d", f), idle, 1'b1);
        end
        expect_equal("uart irq after frames", irq[1], 1'b1);
        read_expect(16'h0024, 32'd1, "uart claims as id 1");
        expect_equal("irq after uart claim", irq[1], 1'b0);
        reg_write(16'h100C, 32'd0);
        reg_write(16'h0024, 32'd1);
        expect_equal("irq after uart complete", irq, 2'b00);
        end_test("uart frame");
    endtask

    task automatic run_tests();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        run_patterns();
        probe_unmapped();
        timer_claim();
        arbitration();
        uart_frame();
    endtask

    initial begin : main
        bit ok;
        rst = 1'b1;
        req = '0;
        void'($urandom(74));
        load_patterns(ok);
        load_done = ok;
        if (!ok) begin
            $display("no patterns loaded, tests not run");
            $display("Checks failed");
        end else begin
            run_tests();
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (load_done);
        limit = pat_wr.size() * 10 + 2 * 10 * UART_DIV + 2000;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verification/periph_patterns.txt
# op addr wdata expected_rdata expected_error
# writes answer zero data, unmapped regions answer DEADBEEF with the error flag
W 0004 00000005 00000000 0
R 0004 00000000 00000005 0
W 0008 00000003 00000000 0
R 0008 00000000 00000003 0
W 000C 00000007 00000000 0
R 000C 00000000 00000007 0
W 0010 0000000E 00000000 0
R 0010 00000000 0000000E 0
W 0014 0000000A 00000000 0
R 0014 00000000 0000000A 0
W 0018 00000004 00000000 0
R 0018 00000000 00000004 0
W 001C 00000002 00000000 0
R 001C 00000000 00000002 0
R 0020 00000000 00000000 0
W 2004 0000ABCD 00000000 0
R 2004 00000000 0000ABCD 0
W 2014 12345678 00000000 0
R 2014 00000000 12345678 0
R 2008 00000000 00000000 0
W 1004 00000009 00000000 0
R 1004 00000000 00000009 0
R 1008 00000000 00000000 0
W 1004 00000004 00000000 0
R 0030 00000000 00000000 0
W 3004 12345678 DEADBEEF 1
R 3004 00000000 DEADBEEF 1
R F010 00000000 DEADBEEF 1
R 0004 00000000 00000005 0

//--- tb.f
+incdir+source
source/periph_pkg.sv
source/periph_bus_ctrl.sv
source/periph_irq_ctrl.sv
source/periph_timer.sv
source/periph_uart_tx.sv
source/periph_top.sv
verification/periph_tb.sv

//--- Bender.yml
package:
  name: periph

sources:
  - include_dirs:
      - source
    files:
      - source/periph_pkg.sv
      - source/periph_bus_ctrl.sv
      - source/periph_irq_ctrl.sv
      - source/periph_timer.sv
      - source/periph_uart_tx.sv
      - source/periph_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/periph_tb.sv
